// ==== src.f ====
matrix_pkg.sv
icon_pkg.sv
scan_if.sv
scan_tick.sv
icon_sequencer.sv
glyph_rom.sv
matrix_scanner.sv
dot_matrix_top.sv
dot_matrix_checker.sv
tb_dot_matrix.sv

// ==== Bender.yml ====
package:
  name: dot_matrix

sources:
  - matrix_pkg.sv
  - icon_pkg.sv
  - scan_if.sv
  - scan_tick.sv
  - icon_sequencer.sv
  - glyph_rom.sv
  - matrix_scanner.sv
  - dot_matrix_top.sv
  - target: test
    files:
      - dot_matrix_checker.sv
      - tb_dot_matrix.sv

// ==== tb_dot_matrix.sv ====
`timescale 1ns/1ps

module tb_dot_matrix;

    localparam int SCAN_DIV        = 4;
    localparam int FRAMES_PER_STEP = 2;
    localparam int FRAME_CYCLES    = 8 * SCAN_DIV;

    typedef struct packed {
        logic       st;
        logic       temp;
        logic       anim;
        logic [3:0] num;
        logic [7:0] frames; // hold length
    } entry_t;

    logic        clk;
    logic        rst;
    logic        st;
    logic        temp;
    logic        anim;
    logic [3:0]  num;
    logic [7:0]  row;
    logic [7:0]  colg;
    logic [7:0]  colr;
    int          error_count;
    entry_t      entries[$];
    int unsigned seed;
    int          cycle_limit = 0;
    int          cycles = 0;

    dot_matrix_top #(
        .SCAN_DIV        (SCAN_DIV),
        .FRAMES_PER_STEP (FRAMES_PER_STEP)
    ) dot_matrix_top_i (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .anim (anim),
        .num  (num),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    dot_matrix_checker #(
        .SCAN_DIV        (SCAN_DIV),
        .FRAMES_PER_STEP (FRAMES_PER_STEP)
    ) dot_matrix_checker_i (
        .clk         (clk),
        .rst         (rst),
        .st          (st),
        .temp        (temp),
        .anim        (anim),
        .num         (num),
        .row         (row),
        .colg        (colg),
        .colr        (colr),
        .error_count (error_count)
    );

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_entry(input logic s, input logic t, input logic a,
                             input logic [3:0] n, input logic [7:0] f);
        entry_t e;
        e.st     = s;
        e.temp   = t;
        e.anim   = a;
        e.num    = n;
        e.frames = f;
        entries.push_back(e);
    endtask

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit)
        begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial
    begin
        int total_frames;
        rst  = 1'b1;
        st   = 1'b0;
        temp = 1'b0;
        anim = 1'b0;
        num  = 4'd0;
        seed = 78;

        add_entry(0, 0, 0, 4'd0,  1);  // blank after reset
        add_entry(1, 0, 0, 4'd5,  3);
        add_entry(1, 1, 0, 4'd5,  2);
        add_entry(1, 0, 0, 4'd8,  2);
        add_entry(1, 0, 0, 4'd11, 2);
        add_entry(1, 0, 0, 4'd10, 2);
        add_entry(1, 1, 0, 4'd6,  2);
        add_entry(1, 0, 0, 4'd9,  2);
        add_entry(1, 1, 0, 4'd7,  2);
        add_entry(0, 1, 0, 4'd3,  1);  // blank mid run
        add_entry(1, 0, 0, 4'd13, 2);
        add_entry(1, 0, 1, 4'd3,  18); // fill animation
        add_entry(1, 1, 1, 4'd0,  12);
        add_entry(1, 0, 0, 4'd2,  2);
        for (int k = 0; k < 6; k++)
        begin
            seed = lcg_next(seed);
            add_entry(1, seed[20], 0, seed[19:16], 2);
        end

        total_frames = 0;
        foreach (entries[i])
            total_frames += entries[i].frames;
        cycle_limit = total_frames * FRAME_CYCLES + 200;

        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        foreach (entries[i])
        begin
            st   = entries[i].st;
            temp = entries[i].temp;
            anim = entries[i].anim;
            num  = entries[i].num;
            repeat (entries[i].frames * FRAME_CYCLES) @(posedge clk);
            #2;
        end

        $display("checks done, %0d errors", error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== dot_matrix_checker.sv ====
`timescale 1ns/1ps

module dot_matrix_checker
    import matrix_pkg::*;
    import icon_pkg::*;
#(
    parameter int SCAN_DIV        = 4,
    parameter int FRAMES_PER_STEP = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     st,
    input  logic     temp,
    input  logic     anim,
    input  icon_t    num,
    input  row_sel_t row,
    input  col_t     colg,
    input  col_t     colr,
    output int       error_count
);

    // reference values as the DUT saw them at the last edges
    logic     st_q;
    logic     temp_q;
    logic     anim_q;
    logic     anim_qq;
    icon_t    num_q;
    icon_t    num_qq;

    icon_t    fref_num = ICON_FILL0; // icon of the frame on display
    logic     fref_anim = 1'b0;
    row_sel_t prev_row = ROW_NONE;
    int       row_cycles = 0;
    int       row_limit = SCAN_DIV + 1;
    int       rows_seen = 0;
    int       green_sum = 0;
    logic     all_full = 1'b0;
    logic     red_any = 1'b0;
    logic     in_frame = 1'b0;
    logic     frame_wrap = 1'b0;  // frame began at a 7 -> 0 wrap
    logic     anim_track = 1'b0;
    logic     anim_first = 1'b0;
    int       base_sum = 0;       // lit green dots of the first fill level
    int       prev_sum = 0;
    int       same_cnt = 0;
    int       steps = 0;

    initial
        error_count = 0;

    always @(posedge clk or posedge rst)
    begin
        if (rst)
            st_q <= 1'b0;
        else
            st_q <= st;
    end

    always @(posedge clk)
    begin
        temp_q  <= temp;
        anim_q  <= anim;
        anim_qq <= anim_q;
        num_q   <= num;
        num_qq  <= num_q;
    end

    task automatic flag_error(input string msg);
        error_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    function automatic int row_index(input row_sel_t sel);
        int idx;
        idx = 0;
        for (int i = 0; i < MATRIX_ROWS; i++)
            if (!sel[i])
                idx = i;
        return idx;
    endfunction

    task automatic check_anim_step();
        if (anim_first)
        begin
            base_sum   = green_sum;
            same_cnt   = 1;
            steps      = 0;
            anim_first = 1'b0;
        end
        else if (green_sum == prev_sum)
        begin
            same_cnt++;
            if (same_cnt > FRAMES_PER_STEP)
                flag_error($sformatf("animation step held for %0d frames", same_cnt));
        end
        else
        begin
            if (same_cnt != FRAMES_PER_STEP)
                flag_error($sformatf("animation step lasted %0d frames", same_cnt));
            if (green_sum > prev_sum)
            begin
                steps++;
                if (steps > ANIM_LAST)
                    flag_error("animation grew past the last fill level");
            end
            else
            begin
                if (steps != ANIM_LAST || green_sum != base_sum)
                    flag_error($sformatf("animation fell back after step %0d", steps));
                steps = 0;
            end
            same_cnt = 1;
        end
        prev_sum = green_sum;
        if (all_full != (steps == ANIM_LAST))
            flag_error($sformatf("full square shown=%0b at animation step %0d", all_full, steps));
    endtask

    task automatic end_frame();
        if (in_frame && rows_seen == MATRIX_ROWS)
        begin
            if (!fref_anim && fref_num == ICON_FILL5 && !all_full)
                flag_error("icon 5 is not a full green square");
            if (!fref_anim && (fref_num == ICON_ALARM || fref_num == ICON_CLOCK) && !red_any)
                flag_error($sformatf("icon %0d shows no red dot in a frame", fref_num));
            if (fref_anim && frame_wrap && anim_track)
                check_anim_step();
        end
    endtask

    task automatic start_frame(input logic by_wrap);
        if (by_wrap)
        begin
            if (anim_qq && !fref_anim)
            begin
                anim_track = 1'b1; // sequence restarts at fill level 0
                anim_first = 1'b1;
            end
            else if (!anim_qq)
                anim_track = 1'b0;
            fref_num  = num_qq;
            fref_anim = anim_qq;
        end
        frame_wrap = by_wrap;
        in_frame   = 1'b1;
        rows_seen  = 0;
        green_sum  = 0;
        all_full   = 1'b1;
        red_any    = 1'b0;
    endtask

    task automatic new_row();
        int idx;
        int prev_idx;
        idx = row_index(row);
        if (prev_row == ROW_NONE)
        begin
            if (idx != 0)
                flag_error($sformatf("scan resumed at row %0d", idx));
            else
                start_frame(1'b0);
            row_limit = SCAN_DIV + 1; // first tick plus the output register
        end
        else
        begin
            prev_idx = row_index(prev_row);
            if (idx != (prev_idx + 1) % MATRIX_ROWS)
                flag_error($sformatf("row %0d followed row %0d", idx, prev_idx));
            if (idx == 0)
            begin
                end_frame();
                start_frame(1'b1);
            end
            row_limit = SCAN_DIV;
        end
        row_cycles = 1;
        rows_seen++;
        green_sum += $countones(colg);
        all_full  = all_full && (colg == '1);
    endtask

    task automatic check_colours();
        logic is_fill;
        logic shaped;
        logic amber;
        is_fill = fref_anim || (fref_num <= ANIM_LAST);
        shaped  = !fref_anim && (fref_num == ICON_DRAIN || fref_num == ICON_SPIN
                                 || fref_num == ICON_FLAME);
        amber   = shaped || (temp_q && is_fill);
        if (amber && colr != colg)
            flag_error($sformatf("icon %0d colr %h differs from colg %h", fref_num, colr, colg));
        else if (!amber && is_fill && colr != '0)
            flag_error($sformatf("fill icon lit red %h with temp low", colr));
        if (!fref_anim)
        begin
            if ((fref_num == ICON_ALARM || fref_num == ICON_CLOCK) && colg != '0)
                flag_error($sformatf("red-only icon %0d lit green %h", fref_num, colg));
            if (fref_num == ICON_DROP && colr != '0)
                flag_error($sformatf("drop icon lit red %h", colr));
            if (fref_num > ICON_CLOCK && (colg != '0 || colr != '0))
                flag_error($sformatf("unused code %0d is not dark", fref_num));
        end
        red_any = red_any || (colr != '0);
    endtask

    // outputs settle on the rising edge, so look at them on the falling one
    always @(negedge clk)
    begin
        if (rst || !st_q)
        begin
            if (row != ROW_NONE || colg != '0 || colr != '0)
                flag_error($sformatf("display not blank, row %b colg %h colr %h",
                                     row, colg, colr));
            if (rst)
            begin
                fref_num  = ICON_FILL0;
                fref_anim = 1'b0;
            end
            in_frame   = 1'b0;
            anim_track = 1'b0; // sequencer paused, step count no longer known
            row_cycles = 0;
        end
        else if ($countones(~row) != 1)
            flag_error($sformatf("row select %b does not drive exactly one row", row));
        else
        begin
            if (row != prev_row)
                new_row();
            else
            begin
                row_cycles++;
                if (row_cycles == row_limit + 1)
                    flag_error($sformatf("row %b held past the scan period", row));
            end
            check_colours();
        end
        prev_row = row;
    end

endmodule

// ==== dot_matrix_top.sv ====
`timescale 1ns/1ps

module dot_matrix_top
    import icon_pkg::*;
#(
    parameter int SCAN_DIV        = 50,
    parameter int FRAMES_PER_STEP = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       st,
    input  logic       temp,
    input  logic       anim,
    input  logic [3:0] num,
    output logic [7:0] row,
    output logic [7:0] colg,
    output logic [7:0] colr
);

    logic  tick;
    logic  frame_start;
    icon_t icon;

    scan_if bus_if ();

    scan_tick #(
        .SCAN_DIV (SCAN_DIV)
    ) scan_tick_i (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .tick (tick)
    );

    icon_sequencer #(
        .FRAMES_PER_STEP (FRAMES_PER_STEP)
    ) icon_sequencer_i (
        .clk         (clk),
        .rst         (rst),
        .num         (num),
        .anim        (anim),
        .frame_start (frame_start),
        .icon        (icon)
    );

    glyph_rom glyph_rom_i (
        .icon (icon),
        .bus  (bus_if.rom)
    );

    matrix_scanner matrix_scanner_i (
        .clk         (clk),
        .rst         (rst),
        .st          (st),
        .temp        (temp),
        .tick        (tick),
        .bus         (bus_if.scanner),
        .frame_start (frame_start),
        .row         (row),
        .colg        (colg),
        .colr        (colr)
    );

endmodule

// ==== matrix_scanner.sv ====
`timescale 1ns/1ps

module matrix_scanner
    import matrix_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     st,
    input  logic     temp,
    input  logic     tick,
    scan_if.scanner  bus,
    output logic     frame_start,
    output row_sel_t row,
    output col_t     colg,
    output col_t     colr
);

    row_idx_t row_idx;
    row_sel_t row_sel;
    logic     last_row;

    assign last_row    = (row_idx == row_idx_t'(MATRIX_ROWS - 1));
    assign frame_start = st && tick && last_row; // wrap 7 -> 0
    assign bus.row_idx = row_idx;
    assign bus.temp    = temp;

    always_comb
    begin
        row_sel          = ROW_NONE;
        row_sel[row_idx] = 1'b0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (!st)
            row_idx <= '0;
        else if (tick)
            row_idx <= last_row ? '0 : row_idx + 1'b1;
    end

    // outputs lag row_idx by one cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= ROW_NONE;
            colg <= '0;
            colr <= '0;
        end
        else if (!st)
        begin
            row  <= ROW_NONE; // blank
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= row_sel;
            colg <= bus.colg;
            colr <= bus.colr;
        end
    end

endmodule

// ==== glyph_rom.sv ====
`timescale 1ns/1ps

module glyph_rom
    import matrix_pkg::*;
    import icon_pkg::*;
(
    input  icon_t      icon,
    scan_if.rom        bus
);

    col_t green;
    col_t red;
    col_t red_shape;  // pattern of the red-only icons
    logic copy_green; // icon shows amber

    always_comb
    begin
        green = '0;
        case (icon)
            ICON_FILL0:
                case (bus.row_idx)
                    3'd2, 3'd5: green = 8'b0001_1000;
                    3'd3, 3'd4: green = 8'b0011_1100;
                    default:    green = '0;
                endcase
            ICON_FILL1:
                case (bus.row_idx)
                    3'd2, 3'd5: green = 8'b0011_1000;
                    3'd3, 3'd4: green = 8'b0111_1100;
                    default:    green = '0;
                endcase
            ICON_FILL2:
                case (bus.row_idx)
                    3'd2, 3'd5: green = 8'b0011_1100;
                    3'd3, 3'd4: green = 8'b0111_1110;
                    default:    green = '0;
                endcase
            ICON_FILL3:
                case (bus.row_idx)
                    3'd1, 3'd6:             green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: green = 8'b0111_1110;
                    default:                green = '0;
                endcase
            ICON_FILL4:
                case (bus.row_idx)
                    3'd0, 3'd7: green = 8'b0011_1100;
                    3'd1, 3'd6: green = 8'b0111_1110;
                    default:    green = 8'b1111_1111;
                endcase
            ICON_FILL5:
                green = 8'b1111_1111; // full square
            ICON_DRAIN:
                case (bus.row_idx)
                    3'd0:    green = 8'b1100_0011;
                    3'd1:    green = 8'b1110_0011;
                    3'd2:    green = 8'b1111_0001;
                    3'd3:    green = 8'b1110_0011;
                    3'd4:    green = 8'b1100_0111;
                    3'd5:    green = 8'b1110_0111;
                    3'd6:    green = 8'b1111_0111;
                    default: green = 8'b1111_1011;
                endcase
            ICON_SPIN:
                case (bus.row_idx)
                    3'd1:    green = 8'b0000_0001;
                    3'd2:    green = 8'b1000_0001;
                    3'd3:    green = 8'b1100_0011;
                    3'd4:    green = 8'b1000_0011;
                    3'd5:    green = 8'b1100_0111;
                    3'd6:    green = 8'b1110_0111;
                    3'd7:    green = 8'b1111_0011;
                    default: green = '0;
                endcase
            ICON_FLAME:
                case (bus.row_idx)
                    3'd2:    green = 8'b0110_0000;
                    3'd3:    green = 8'b1111_1100;
                    3'd4:    green = 8'b0011_1111;
                    3'd5:    green = 8'b0011_1110;
                    3'd6:    green = 8'b0001_1100;
                    default: green = '0;
                endcase
            ICON_DROP:
                case (bus.row_idx)
                    3'd2:       green = 8'b0001_1000;
                    3'd3:       green = 8'b0011_1100;
                    3'd4, 3'd5: green = 8'b0111_1110;
                    3'd6:       green = 8'b0010_0100;
                    default:    green = '0;
                endcase
            default: green = '0; // alarm, clock and unused codes
        endcase
    end

    always_comb
    begin
        red_shape = '0;
        if (icon == ICON_ALARM)
        begin
            case (bus.row_idx)
                3'd1, 3'd7: red_shape = 8'b0011_1000;
                3'd2:       red_shape = 8'b0100_0100;
                3'd3:       red_shape = 8'b0101_1010;
                3'd4:       red_shape = 8'b0100_1010;
                3'd5:       red_shape = 8'b0011_0010;
                3'd6:       red_shape = 8'b1100_0100;
                default:    red_shape = '0;
            endcase
        end
        else if (icon == ICON_CLOCK)
        begin
            case (bus.row_idx)
                3'd0, 3'd2: red_shape = 8'b1110_0000;
                3'd1:       red_shape = 8'b0110_0000;
                3'd3:       red_shape = 8'b0011_0000;
                3'd4:       red_shape = 8'b0011_0001;
                3'd5:       red_shape = 8'b0011_0011;
                3'd6:       red_shape = 8'b0011_1110;
                default:    red_shape = 8'b0001_1100;
            endcase
        end
    end

    // hot: fill icons go amber too
    assign copy_green = (icon == ICON_DRAIN) || (icon == ICON_SPIN) || (icon == ICON_FLAME)
                        || (bus.temp && icon <= ANIM_LAST);

    assign red      = copy_green ? green : red_shape;
    assign bus.colg = green;
    assign bus.colr = red;

endmodule

// ==== icon_sequencer.sv ====
`timescale 1ns/1ps

module icon_sequencer
    import icon_pkg::*;
#(
    parameter int FRAMES_PER_STEP = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  icon_t num,
    input  logic  anim,
    input  logic  frame_start,
    output icon_t icon
);

    localparam int CNT_W = $clog2(FRAMES_PER_STEP + 1);

    logic [CNT_W-1:0] frame_cnt;
    logic             anim_on;   // animation seen at the last frame start
    logic             step_due;

    assign step_due = (frame_cnt == CNT_W'(FRAMES_PER_STEP - 1));

    // icon only moves at a frame boundary, so a frame never mixes two icons
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            icon      <= ICON_FILL0;
            frame_cnt <= '0;
            anim_on   <= 1'b0;
        end
        else if (frame_start)
        begin
            anim_on <= anim;
            if (!anim)
            begin
                icon      <= num;
                frame_cnt <= '0;
            end
            else if (!anim_on)
            begin
                icon      <= ICON_FILL0; // fresh start of the fill animation
                frame_cnt <= '0;
            end
            else if (step_due)
            begin
                frame_cnt <= '0;
                icon      <= (icon == ANIM_LAST) ? ICON_FILL0 : icon + 1'b1;
            end
            else
            begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== scan_tick.sv ====
`timescale 1ns/1ps

module scan_tick #(
    parameter int SCAN_DIV = 50
) (
    input  logic clk,
    input  logic rst,
    input  logic st,
    output logic tick
);

    localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (!st)
        begin
            cnt  <= '0; // restart the row period when the display comes back
            tick <= 1'b0;
        end
        else if (cnt == CNT_W'(SCAN_DIV - 1))
        begin
            cnt  <= '0;
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== scan_if.sv ====
`timescale 1ns/1ps

interface scan_if
    import matrix_pkg::*;
();

    row_idx_t row_idx;
    logic     temp;
    col_t     colg;
    col_t     colr;

    modport scanner (
        output row_idx,
        output temp,
        input  colg,
        input  colr
    );

    modport rom (
        input  row_idx,
        input  temp,
        output colg,
        output colr
    );

endinterface

// ==== icon_pkg.sv ====
package icon_pkg;

    typedef logic [3:0] icon_t;

    // fill levels, small blob up to full square
    localparam icon_t ICON_FILL0 = 4'd0;
    localparam icon_t ICON_FILL1 = 4'd1;
    localparam icon_t ICON_FILL2 = 4'd2;
    localparam icon_t ICON_FILL3 = 4'd3;
    localparam icon_t ICON_FILL4 = 4'd4;
    localparam icon_t ICON_FILL5 = 4'd5;

    localparam icon_t ICON_DRAIN = 4'd6;
    localparam icon_t ICON_SPIN  = 4'd7;
    localparam icon_t ICON_ALARM = 4'd8;  // red only
    localparam icon_t ICON_FLAME = 4'd9;
    localparam icon_t ICON_DROP  = 4'd10; // green only
    localparam icon_t ICON_CLOCK = 4'd11; // red only

    // animation walks ICON_FILL0 .. ANIM_LAST
    localparam icon_t ANIM_LAST = ICON_FILL5;

endpackage

// ==== matrix_pkg.sv ====
package matrix_pkg;

    // panel geometry
    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 8;

    // row counter, one value per scanned row
    typedef logic [$clog2(MATRIX_ROWS)-1:0] row_idx_t;

    // one bit per row, low drives the row
    typedef logic [MATRIX_ROWS-1:0] row_sel_t;

    // one bit per column of one colour, high lights the dot
    typedef logic [MATRIX_COLS-1:0] col_t;

    localparam row_sel_t ROW_NONE = '1; // no row driven

endpackage
